// File: list.f
+incdir+source
source/issue_pkg.sv
source/instr_decoder.sv
source/rename_table.sv
source/lane_credits.sv
source/issue_sequencer.sv
source/issue_top.sv
sim/issue_clock_gen.sv
sim/issue_checker.sv
sim/issue_tb.sv

// File: Bender.yml
package:
  name: issue_front_end

sources:
  - include_dirs:
      - source
    files:
      - source/issue_pkg.sv
      - source/instr_decoder.sv
      - source/rename_table.sv
      - source/lane_credits.sv
      - source/issue_sequencer.sv
      - source/issue_top.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - sim/issue_clock_gen.sv
      - sim/issue_checker.sv
      - sim/issue_tb.sv

// File: sim/issue_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "issue_settings.svh"

module issue_tb;
    import issue_pkg::*;

    localparam int          NL        = `ISSUE_NUM_LANES;
    localparam int          MEM_WORDS = 256;
    localparam int          CYCLES    = 2000;
    localparam int          STALL_MAX = 400;
    localparam logic [31:0] BASE      = `ISSUE_RESET_PC;

    logic                           clk;
    logic                           rst_n;
    logic [31:0]                    imem_addr;
    logic [NL-1:0][31:0]            imem_data;
    issue_packet_t [NL-1:0]         packet_out;
    logic [NL-1:0]                  credit_return;
    logic [`ISSUE_NUM_PHY_REGS-1:0] pr_not_idle;

    logic [31:0] imem [MEM_WORDS];
    logic [31:0] rng;

    // reference model state
    logic [`ISSUE_PR_W-1:0]     m_rat [32];
    logic [31:0]                m_pc;
    logic [`ISSUE_ID_WIDTH-1:0] m_id;
    logic                       m_pend;
    logic [31:0]                m_target;
    int                         m_credit [NL];
    issue_packet_t [NL-1:0]     exp_pkt;

    int outstanding [NL];
    int jumps;
    int spills;
    int total_issued;

    issue_clock_gen u_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    issue_top dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .imem_addr     (imem_addr),
        .imem_data     (imem_data),
        .packet_out    (packet_out),
        .credit_return (credit_return),
        .pr_not_idle   (pr_not_idle)
    );

    bind issue_top issue_checker u_checker (
        .clk           (clk),
        .rst_n         (rst_n),
        .credit_return (credit_return),
        .packet_out    (packet_out)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    // addiu filler built from every address bit
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return {6'h09, addr[11:7], addr[6:2], addr[31:16] ^ addr[15:0]};
    endfunction

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        logic [31:0] off;
        off = addr - BASE;
        if (off < 32'(MEM_WORDS * 4)) begin
            return imem[off[31:2]];
        end
        return fill_word(addr);
    endfunction

    function automatic logic [31:0] make_instr();
        logic [31:0] r;
        logic [31:0] f;
        logic [31:0] tgt;
        logic [5:0]  op;
        int          pick;
        r    = next_rand();
        f    = next_rand();
        pick = int'(r % 100);
        if (pick < 25) begin
            // addu, subu, and, or, sll, slt, jr
            case (r[31:29])
                3'd0: op = 6'h21;
                3'd1: op = 6'h23;
                3'd2: op = 6'h24;
                3'd3: op = 6'h25;
                3'd4: op = 6'h00;
                3'd5: op = 6'h2a;
                3'd6: op = 6'h08;
                default: op = 6'h21;
            endcase
            return {6'h00, f[25:11], 5'd0, op};
        end else if (pick < 50) begin
            op = (r[31:30] == 2'd0) ? 6'h0f : (r[29] ? 6'h09 : 6'h0d);
            return {op, f[25:0]};
        end else if (pick < 70) begin
            return {r[31] ? 6'h23 : 6'h2b, f[25:0]};
        end else if (pick < 80) begin
            tgt = BASE + ((f % MEM_WORDS) << 2);
            return {r[31] ? 6'h03 : 6'h02, tgt[27:2]};
        end
        case (r[31:30])
            2'd0: op = 6'h04;
            2'd1: op = 6'h05;
            2'd2: op = 6'h1c;
            default: op = 6'h3f;
        endcase
        return {op, f[25:0]};
    endfunction

    // register jumps and branches decode as non-writing ops
    function automatic instr_info_t decode_word(input logic [31:0] w);
        instr_info_t d;
        d             = '0;
        d.rs          = w[25:21];
        d.rt          = w[20:16];
        d.jump_target = w[25:0];
        case (w[31:26])
            6'h00: begin
                if (w[5:0] == 6'h08 || w[5:0] == 6'h09) begin
                    d.read_rs = 1'b1;
                end else begin
                    d.read_rs   = !(w[5:0] == 6'h00 || w[5:0] == 6'h02 || w[5:0] == 6'h03);
                    d.read_rt   = 1'b1;
                    d.write_gpr = 1'b1;
                    d.dst_lr    = w[15:11];
                end
            end
            6'h02: d.cf_kind = CF_JUMP_IMM;
            6'h03: begin
                d.cf_kind   = CF_JUMP_IMM;
                d.is_link   = 1'b1;
                d.write_gpr = 1'b1;
                d.dst_lr    = 5'd31;
            end
            6'h04, 6'h05, 6'h2b: begin
                d.read_rs = 1'b1;
                d.read_rt = 1'b1;
            end
            6'h09, 6'h0d, 6'h23: begin
                d.read_rs   = 1'b1;
                d.write_gpr = 1'b1;
                d.dst_lr    = w[20:16];
            end
            6'h0f: begin
                d.write_gpr = 1'b1;
                d.dst_lr    = w[20:16];
            end
            default: d.write_gpr = 1'b0;
        endcase
        return d;
    endfunction

    task automatic stop_with_failure();
        $display("TESTS FAILED");
        $fatal(1, "stopping on the first error");
    endtask

    task automatic report_failure(input string why);
        $display("ERROR at %0t ns: %s", $time, why);
        stop_with_failure();
    endtask

    task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    // what the front end does at the next rising edge
    task automatic model_step(input logic [NL-1:0] ret,
                              input logic [`ISSUE_NUM_PHY_REGS-1:0] pni);
        logic [`ISSUE_NUM_PHY_REGS-1:0] used;
        logic [31:0]                    pc0;
        logic [31:0]                    ip;
        instr_info_t                    d;
        logic [`ISSUE_PR_W-1:0]         pick;
        logic [NL-1:0]                  issued;
        logic                           found;
        logic                           stop;
        int                             slot;
        used       = pni;
        used[31:0] = '1;
        for (int lr = 1; lr < 32; lr++) begin
            used[m_rat[lr]] = 1'b1;
        end
        pc0    = m_pc;
        slot   = 0;
        stop   = 1'b0;
        issued = '0;
        if (m_pend) begin
            spills++;
        end
        for (int l = 0; l < NL; l++) begin
            exp_pkt[l] = '0;
            if (m_credit[l] != 0 && !stop) begin
                ip    = pc0 + 32'(4 * slot);
                d     = decode_word(fetch_word(ip));
                found = 1'b1;
                pick  = '0;
                if (d.write_gpr && d.dst_lr != 5'd0) begin
                    found = 1'b0;
                    for (int p = 32; p < `ISSUE_NUM_PHY_REGS; p++) begin
                        if (!found && !used[p]) begin
                            found = 1'b1;
                            pick  = `ISSUE_PR_W'(p);
                        end
                    end
                end
                if (!found) begin
                    stop = 1'b1;
                end else begin
                    exp_pkt[l].valid    = 1'b1;
                    exp_pkt[l].pc       = d.is_link ? ip + 32'd4 : ip;
                    exp_pkt[l].issue_id = m_id + `ISSUE_ID_WIDTH'(slot);
                    exp_pkt[l].phy_rs   = (d.read_rs && d.rs != 5'd0) ? m_rat[d.rs] : '0;
                    exp_pkt[l].phy_rt   = (d.read_rt && d.rt != 5'd0) ? m_rat[d.rt] : '0;
                    exp_pkt[l].phy_dst  = pick;
                    exp_pkt[l].link     = d.is_link;
                    if (pick != '0) begin
                        used[pick]      = 1'b1;
                        m_rat[d.dst_lr] = pick;
                    end
                    issued[l] = 1'b1;
                    if (m_pend) begin
                        // redirect once the delay slot is out
                        m_pc   = m_target;
                        m_pend = 1'b0;
                        stop   = 1'b1;
                    end else begin
                        m_pc = ip + 32'd4;
                        if (d.cf_kind == CF_JUMP_IMM) begin
                            m_pend   = 1'b1;
                            m_target = {ip[31:28], d.jump_target, 2'b00};
                            jumps++;
                        end
                    end
                    slot++;
                end
            end
        end
        m_id         = m_id + `ISSUE_ID_WIDTH'(slot);
        total_issued = total_issued + slot;
        for (int l = 0; l < NL; l++) begin
            m_credit[l] = m_credit[l] - int'(issued[l]) + int'(ret[l]);
        end
    endtask

    task automatic compare_outputs();
        for (int l = 0; l < NL; l++) begin
            check_value($sformatf("lane %0d valid", l), packet_out[l].valid, exp_pkt[l].valid);
            if (exp_pkt[l].valid) begin
                check_value($sformatf("lane %0d pc", l), packet_out[l].pc, exp_pkt[l].pc);
                check_value($sformatf("lane %0d issue_id", l),
                            packet_out[l].issue_id, exp_pkt[l].issue_id);
                check_value($sformatf("lane %0d phy_rs", l),
                            packet_out[l].phy_rs, exp_pkt[l].phy_rs);
                check_value($sformatf("lane %0d phy_rt", l),
                            packet_out[l].phy_rt, exp_pkt[l].phy_rt);
                check_value($sformatf("lane %0d phy_dst", l),
                            packet_out[l].phy_dst, exp_pkt[l].phy_dst);
                check_value($sformatf("lane %0d link", l), packet_out[l].link, exp_pkt[l].link);
            end
        end
        check_value("imem_addr", imem_addr, m_pc);
    endtask

    initial begin
        logic [NL-1:0]                  ret;
        logic [`ISSUE_NUM_PHY_REGS-1:0] pni;
        logic [31:0]                    r_a;
        logic [31:0]                    r_b;
        logic                           withhold;
        int                             waited;
        int                             idle;

        credit_return = '0;
        pr_not_idle   = '0;
        imem_data     = '0;
        rng           = 32'h5dc4_9082;
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = make_instr();
        end
        m_rat[0] = '0;
        for (int i = 1; i < 32; i++) begin
            m_rat[i] = `ISSUE_PR_W'(i);
        end
        m_pc         = BASE;
        m_id         = '0;
        m_pend       = 1'b0;
        m_target     = '0;
        exp_pkt      = '0;
        jumps        = 0;
        spills       = 0;
        total_issued = 0;
        for (int l = 0; l < NL; l++) begin
            m_credit[l]    = `ISSUE_LANE_CREDITS;
            outstanding[l] = 0;
        end

        waited = 0;
        while (rst_n !== 1'b1) begin
            if (waited > 20) begin
                report_failure("reset was never released");
            end
            @(posedge clk);
            #1;
            waited++;
            compare_outputs();
        end

        pni  = '0;
        idle = 0;
        for (int cycle = 0; cycle < CYCLES; cycle++) begin
            compare_outputs();
            if (dut.u_checker.fail_count != 0) begin
                report_failure("a bound assertion failed");
            end
            for (int l = 0; l < NL; l++) begin
                if (packet_out[l].valid) begin
                    outstanding[l]++;
                end
                if (outstanding[l] > `ISSUE_LANE_CREDITS) begin
                    report_failure($sformatf("lane %0d holds more packets than credits", l));
                end
                // only non-writers get through while nothing is free
                if (packet_out[l].valid && (&pr_not_idle[`ISSUE_NUM_PHY_REGS-1:32])) begin
                    check_value($sformatf("lane %0d phy_dst with no free register", l),
                                packet_out[l].phy_dst, '0);
                end
            end
            idle = (|{packet_out[NL-1].valid, packet_out[0].valid}) ? 0 : idle + 1;
            if (idle > STALL_MAX) begin
                report_failure("no packet was issued for too many cycles");
            end

            if (cycle % 80 == 0) begin
                r_a = next_rand();
                r_b = next_rand();
                case ((cycle / 80) % 4)
                    1: pni = {r_a & r_b, next_rand()};
                    2: pni = '1;
                    default: pni = '0;
                endcase
            end
            withhold = ((cycle / 60) % 3) == 2;
            for (int l = 0; l < NL; l++) begin
                r_a    = next_rand();
                ret[l] = !withhold && outstanding[l] > 0 && r_a[7];
                if (ret[l]) begin
                    outstanding[l]--;
                end
            end
            credit_return = ret;
            pr_not_idle   = pni;
            for (int k = 0; k < NL; k++) begin
                imem_data[k] = fetch_word(imem_addr + 32'(4 * k));
            end
            model_step(ret, pni);
            @(posedge clk);
            #1;
        end
        compare_outputs();

        if (total_issued < 300) begin
            report_failure("too few instructions issued over the run");
        end
        if (jumps == 0 || spills == 0) begin
            report_failure("no jump with a delay slot in a later cycle was seen");
        end
        if (dut.u_checker.fail_count == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            report_failure("a bound assertion failed");
        end
    end

endmodule

`default_nettype wire

// File: sim/issue_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "issue_settings.svh"

module issue_checker (
    input logic                                            clk,
    input logic                                            rst_n,
    input logic [`ISSUE_NUM_LANES-1:0]                     credit_return,
    input issue_pkg::issue_packet_t [`ISSUE_NUM_LANES-1:0] packet_out
);
    int unsigned fail_count = 0;

    // packets a lane holds, not counting the ones on packet_out now
    int held [`ISSUE_NUM_LANES];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int l = 0; l < `ISSUE_NUM_LANES; l++) begin
                held[l] <= 0;
            end
        end else begin
            for (int l = 0; l < `ISSUE_NUM_LANES; l++) begin
                held[l] <= held[l] + int'(packet_out[l].valid) - int'(credit_return[l]);
            end
        end
    end

    for (genvar l = 0; l < `ISSUE_NUM_LANES; l++) begin : g_lane
        // lane with an empty credit count gets nothing
        credit_guard: assert property (@(posedge clk) disable iff (!rst_n)
            packet_out[l].valid |-> (held[l] < `ISSUE_LANE_CREDITS))
        else begin
            $error("lane %0d got a packet with no credit left", l);
            fail_count++;
        end

        dst_range: assert property (@(posedge clk) disable iff (!rst_n)
            packet_out[l].valid |-> (packet_out[l].phy_dst == '0 || packet_out[l].phy_dst >= 32))
        else begin
            $error("lane %0d phy_dst inside the architectural range", l);
            fail_count++;
        end

        if (l > 0) begin : g_order
            id_order: assert property (@(posedge clk) disable iff (!rst_n)
                (packet_out[l].valid && packet_out[l-1].valid) |->
                (packet_out[l].issue_id == packet_out[l-1].issue_id + 1'b1))
            else begin
                $error("issue id out of order between lanes %0d and %0d", l - 1, l);
                fail_count++;
            end
        end
    end

endmodule

`default_nettype wire

// File: sim/issue_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module issue_clock_gen (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset low for the first 8 rising edges
    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// File: source/issue_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "issue_settings.svh"

module issue_top (
    input  logic                                            clk,
    input  logic                                            rst_n,
    output logic [31:0]                                     imem_addr,
    input  logic [`ISSUE_NUM_LANES-1:0][31:0]               imem_data,
    output issue_pkg::issue_packet_t [`ISSUE_NUM_LANES-1:0] packet_out,
    input  logic [`ISSUE_NUM_LANES-1:0]                     credit_return,
    input  logic [`ISSUE_NUM_PHY_REGS-1:0]                  pr_not_idle
);
    import issue_pkg::*;

    instr_info_t  [`ISSUE_NUM_LANES-1:0] dec_info;
    slot_rename_t [`ISSUE_NUM_LANES-1:0] slot_rename;
    slot_cnt_t                           issue_count;
    logic         [`ISSUE_NUM_LANES-1:0] lane_issue;
    logic         [`ISSUE_NUM_LANES-1:0] lane_ready;

    // one decoder per fetch slot
    for (genvar k = 0; k < `ISSUE_NUM_LANES; k++) begin : g_dec
        instr_decoder u_dec (
            .instr (imem_data[k]),
            .info  (dec_info[k])
        );
    end

    rename_table u_rename (
        .clk         (clk),
        .rst_n       (rst_n),
        .info        (dec_info),
        .pr_not_idle (pr_not_idle),
        .issue_count (issue_count),
        .rename      (slot_rename)
    );

    lane_credits u_credits (
        .clk           (clk),
        .rst_n         (rst_n),
        .lane_issue    (lane_issue),
        .credit_return (credit_return),
        .lane_ready    (lane_ready)
    );

    issue_sequencer u_seq (
        .clk         (clk),
        .rst_n       (rst_n),
        .info        (dec_info),
        .rename      (slot_rename),
        .lane_ready  (lane_ready),
        .pc          (imem_addr),
        .issue_count (issue_count),
        .lane_issue  (lane_issue),
        .packet_out  (packet_out)
    );

endmodule

`default_nettype wire

// File: source/issue_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "issue_settings.svh"

module issue_sequencer (
    input  logic                                            clk,
    input  logic                                            rst_n,
    input  issue_pkg::instr_info_t [`ISSUE_NUM_LANES-1:0]   info,
    input  issue_pkg::slot_rename_t [`ISSUE_NUM_LANES-1:0]  rename,
    input  logic [`ISSUE_NUM_LANES-1:0]                     lane_ready,
    output logic [31:0]                                     pc,
    output issue_pkg::slot_cnt_t                            issue_count,
    output logic [`ISSUE_NUM_LANES-1:0]                     lane_issue,
    output issue_pkg::issue_packet_t [`ISSUE_NUM_LANES-1:0] packet_out
);
    import issue_pkg::*;

    logic [`ISSUE_ID_WIDTH-1:0] issue_id;
    logic                       pend_valid;
    logic [31:0]                pend_target;

    issue_packet_t [`ISSUE_NUM_LANES-1:0] packet_next;
    logic [31:0]                          pc_next;
    logic                                 pend_valid_next;
    logic [31:0]                          pend_target_next;

    always_comb begin
        int          slot;
        logic        stop;
        logic [31:0] ip;

        slot             = 0;
        stop             = 1'b0;
        ip               = pc;
        pc_next          = pc;
        pend_valid_next  = pend_valid;
        pend_target_next = pend_target;
        lane_issue       = '0;
        packet_next      = '0;
        // slot k goes to the k-th ready lane
        for (int l = 0; l < `ISSUE_NUM_LANES; l++) begin
            if (lane_ready[l] && !stop) begin
                if (!rename[slot].alloc_ok) begin
                    // no free physical register, hold from here
                    stop = 1'b1;
                end else begin
                    ip                      = pc + 32'(slot << 2);
                    lane_issue[l]           = 1'b1;
                    packet_next[l].valid    = 1'b1;
                    packet_next[l].pc       = info[slot].is_link ? ip + 32'd4 : ip;
                    packet_next[l].issue_id = issue_id + `ISSUE_ID_WIDTH'(slot);
                    packet_next[l].phy_rs   = rename[slot].phy_rs;
                    packet_next[l].phy_rt   = rename[slot].phy_rt;
                    packet_next[l].phy_dst  = rename[slot].phy_dst;
                    packet_next[l].link     = info[slot].is_link;
                    if (pend_valid_next) begin
                        // delay slot out, redirect and drop the rest
                        pc_next         = pend_target_next;
                        pend_valid_next = 1'b0;
                        stop            = 1'b1;
                    end else begin
                        pc_next = ip + 32'd4;
                        if (info[slot].cf_kind == CF_JUMP_IMM) begin
                            pend_valid_next  = 1'b1;
                            pend_target_next = {ip[31:28], info[slot].jump_target, 2'b00};
                        end
                    end
                    slot++;
                end
            end
        end
        issue_count = slot_cnt_t'(slot);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc         <= `ISSUE_RESET_PC;
            issue_id   <= '0;
            pend_valid <= 1'b0;
            packet_out <= '0;
        end else begin
            pc         <= pc_next;
            issue_id   <= issue_id + `ISSUE_ID_WIDTH'(issue_count);
            pend_valid <= pend_valid_next;
            packet_out <= packet_next;
        end
    end

    always_ff @(posedge clk) begin
        pend_target <= pend_target_next;
    end

endmodule

`default_nettype wire

// File: source/lane_credits.sv
`timescale 1ns/1ps
`default_nettype none

`include "issue_settings.svh"

module lane_credits (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [`ISSUE_NUM_LANES-1:0] lane_issue,
    input  logic [`ISSUE_NUM_LANES-1:0] credit_return,
    output logic [`ISSUE_NUM_LANES-1:0] lane_ready
);
    localparam int CNT_W = $clog2(`ISSUE_LANE_CREDITS + 1);
    localparam logic [CNT_W-1:0] FULL = CNT_W'(`ISSUE_LANE_CREDITS);

    logic [`ISSUE_NUM_LANES-1:0][CNT_W-1:0] count;
    logic [`ISSUE_NUM_LANES-1:0][CNT_W-1:0] count_next;

    always_comb begin
        for (int l = 0; l < `ISSUE_NUM_LANES; l++) begin
            count_next[l] = count[l];
            // issue and return in one cycle cancel out
            if (lane_issue[l] && !credit_return[l] && count[l] != '0) begin
                count_next[l] = count[l] - 1'b1;
            end else if (credit_return[l] && !lane_issue[l] && count[l] != FULL) begin
                count_next[l] = count[l] + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int l = 0; l < `ISSUE_NUM_LANES; l++) begin
                count[l] <= FULL;
            end
            lane_ready <= '1;
        end else begin
            count <= count_next;
            for (int l = 0; l < `ISSUE_NUM_LANES; l++) begin
                lane_ready[l] <= (count_next[l] != '0);
            end
        end
    end

endmodule

`default_nettype wire

// File: source/rename_table.sv
`timescale 1ns/1ps
`default_nettype none

`include "issue_settings.svh"

module rename_table (
    input  logic                                           clk,
    input  logic                                           rst_n,
    input  issue_pkg::instr_info_t [`ISSUE_NUM_LANES-1:0]  info,
    input  logic [`ISSUE_NUM_PHY_REGS-1:0]                 pr_not_idle,
    input  issue_pkg::slot_cnt_t                           issue_count,
    output issue_pkg::slot_rename_t [`ISSUE_NUM_LANES-1:0] rename
);
    import issue_pkg::*;

    // logical 1..31, $0 is never mapped
    typedef logic [31:1][`ISSUE_PR_W-1:0] rat_t;

    rat_t rat;
    rat_t rat_after [`ISSUE_NUM_LANES];

    function automatic logic [`ISSUE_PR_W-1:0] map_src(input rat_t tbl, input logic rd_en,
                                                       input logic [4:0] lr);
        if (!rd_en || lr == 5'd0) begin
            return '0;
        end
        return tbl[lr];
    endfunction

    always_comb begin
        rat_t                           work;
        logic [`ISSUE_NUM_PHY_REGS-1:0] used;
        logic                           found;
        logic [`ISSUE_PR_W-1:0]         pick;

        work       = rat;
        found      = 1'b0;
        pick       = '0;
        used       = pr_not_idle;
        used[31:0] = '1;
        for (int lr = 1; lr < 32; lr++) begin
            used[work[lr]] = 1'b1;
        end
        // used only grows during the cycle, so a freed mapping stays taken until commit
        for (int s = 0; s < `ISSUE_NUM_LANES; s++) begin
            rename[s].phy_rs   = map_src(work, info[s].read_rs, info[s].rs);
            rename[s].phy_rt   = map_src(work, info[s].read_rt, info[s].rt);
            rename[s].phy_dst  = '0;
            rename[s].alloc_ok = 1'b1;
            if (info[s].write_gpr && info[s].dst_lr != 5'd0) begin
                found = 1'b0;
                pick  = '0;
                // walk downwards so the lowest free index wins
                for (int p = `ISSUE_NUM_PHY_REGS - 1; p >= 32; p--) begin
                    if (!used[p]) begin
                        found = 1'b1;
                        pick  = `ISSUE_PR_W'(p);
                    end
                end
                rename[s].alloc_ok = found;
                if (found) begin
                    rename[s].phy_dst    = pick;
                    used[pick]           = 1'b1;
                    work[info[s].dst_lr] = pick;
                end
            end
            rat_after[s] = work;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                rat[i] <= `ISSUE_PR_W'(i);
            end
        end else begin
            // last issued slot carries all earlier mappings
            for (int s = 0; s < `ISSUE_NUM_LANES; s++) begin
                if (s < int'(issue_count)) begin
                    rat <= rat_after[s];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: source/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
    input  logic [31:0]            instr,
    output issue_pkg::instr_info_t info
);
    import issue_pkg::*;

    logic [5:0] op_field;
    logic [5:0] funct;

    assign op_field = instr[31:26];
    assign funct    = instr[5:0];

    always_comb begin
        info             = '0;
        info.opcode      = OPC_OTHER;
        info.rs          = instr[25:21];
        info.rt          = instr[20:16];
        info.rd          = instr[15:11];
        info.jump_target = instr[25:0];
        info.cf_kind     = CF_NONE;
        case (op_field)
            6'h00: begin
                info.opcode = OPC_SPECIAL;
                case (funct)
                    // jr / jalr, treated as plain non-writing ops
                    6'h08, 6'h09: info.read_rs = 1'b1;
                    // immediate shifts
                    6'h00, 6'h02, 6'h03: begin
                        info.read_rt   = 1'b1;
                        info.write_gpr = 1'b1;
                        info.dst_lr    = instr[15:11];
                    end
                    default: begin
                        info.read_rs   = 1'b1;
                        info.read_rt   = 1'b1;
                        info.write_gpr = 1'b1;
                        info.dst_lr    = instr[15:11];
                    end
                endcase
            end
            6'h02: begin
                info.opcode  = OPC_J;
                info.cf_kind = CF_JUMP_IMM;
            end
            6'h03: begin
                info.opcode    = OPC_JAL;
                info.cf_kind   = CF_JUMP_IMM;
                info.is_link   = 1'b1;
                info.write_gpr = 1'b1;
                info.dst_lr    = 5'd31;
            end
            6'h04, 6'h05: begin
                // branches read both operands but never redirect here
                info.opcode  = (op_field == 6'h04) ? OPC_BEQ : OPC_BNE;
                info.read_rs = 1'b1;
                info.read_rt = 1'b1;
            end
            6'h09, 6'h0d, 6'h23: begin
                info.opcode    = (op_field == 6'h09) ? OPC_ADDIU :
                                 (op_field == 6'h0d) ? OPC_ORI : OPC_LW;
                info.read_rs   = 1'b1;
                info.write_gpr = 1'b1;
                info.dst_lr    = instr[20:16];
            end
            6'h0f: begin
                info.opcode    = OPC_LUI;
                info.write_gpr = 1'b1;
                info.dst_lr    = instr[20:16];
            end
            6'h2b: begin
                info.opcode  = OPC_SW;
                info.read_rs = 1'b1;
                info.read_rt = 1'b1;
            end
            default: info.opcode = OPC_OTHER;
        endcase
    end

endmodule

`default_nettype wire

// File: source/issue_pkg.sv
`default_nettype none

`include "issue_settings.svh"

package issue_pkg;

    // primary opcode field, anything unlisted decodes as OPC_OTHER
    typedef enum logic [5:0] {
        OPC_SPECIAL = 6'h00,
        OPC_J       = 6'h02,
        OPC_JAL     = 6'h03,
        OPC_BEQ     = 6'h04,
        OPC_BNE     = 6'h05,
        OPC_ADDIU   = 6'h09,
        OPC_ORI     = 6'h0d,
        OPC_LUI     = 6'h0f,
        OPC_LW      = 6'h23,
        OPC_SW      = 6'h2b,
        OPC_OTHER   = 6'h3f
    } opcode_e;

    typedef enum logic {
        CF_NONE     = 1'b0,
        CF_JUMP_IMM = 1'b1
    } cf_kind_e;

    typedef struct packed {
        opcode_e     opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic        read_rs;
        logic        read_rt;
        logic        write_gpr;
        logic [4:0]  dst_lr;
        cf_kind_e    cf_kind;
        logic        is_link;
        logic [25:0] jump_target;
    } instr_info_t;

    typedef struct packed {
        logic                       valid;
        logic [31:0]                pc;
        logic [`ISSUE_ID_WIDTH-1:0] issue_id;
        logic [`ISSUE_PR_W-1:0]     phy_rs;
        logic [`ISSUE_PR_W-1:0]     phy_rt;
        logic [`ISSUE_PR_W-1:0]     phy_dst;
        logic                       link;
    } issue_packet_t;

    typedef struct packed {
        logic [`ISSUE_PR_W-1:0] phy_rs;
        logic [`ISSUE_PR_W-1:0] phy_rt;
        logic [`ISSUE_PR_W-1:0] phy_dst;
        logic                   alloc_ok;
    } slot_rename_t;

    // number of slots issued in one cycle
    typedef logic [$clog2(`ISSUE_NUM_LANES + 1)-1:0] slot_cnt_t;

endpackage

`default_nettype wire

// File: source/issue_settings.svh
`ifndef ISSUE_SETTINGS_SVH
`define ISSUE_SETTINGS_SVH

// lanes, and fetch slots per cycle
`define ISSUE_NUM_LANES 2

`define ISSUE_NUM_PHY_REGS 64
`define ISSUE_PR_W 6

`define ISSUE_ID_WIDTH 8

// packets a lane may hold before it consumes them
`define ISSUE_LANE_CREDITS 2

`define ISSUE_RESET_PC 32'h0000_3000

`endif
